//--- verilog/tlb_consts.svh
`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

//////////////////////////////
// TLB geometry
`define TLB_SETS        32
`define TLB_OFFSETS     4      // Per half-set
`define TLB_BANKS       4      // Parallel VA banks
`define TLB_SET_BITS    5
`define TLB_OFF_BITS    2
`define TLB_BANK_BITS   2

//////////////////////////////
// Address and bus widths
`define TLB_PAGE_BITS   12     // 4 KiB pages
`define TLB_VA_BITS     32
`define TLB_PA_BITS     40
`define TLB_WDATA_BITS  64
`define TLB_WADDR_BITS  32

`endif

//--- verilog/tlb_pkg.sv
`include "tlb_consts.svh"

package tlb_pkg;

   // Entry inside one bank as {set, half, offset}
   typedef logic [`TLB_SET_BITS+`TLB_OFF_BITS:0] va_index_t;

   // PA table entry as the VA index with the bank number below it
   typedef logic [`TLB_SET_BITS+`TLB_OFF_BITS+`TLB_BANK_BITS:0] pa_index_t;

   typedef struct packed {
      logic [`TLB_VA_BITS-1:0] vaddr;
      logic                    write;  // 1 for a write access
   } lookup_req_t;

   typedef struct packed {
      logic                       we;
      logic [`TLB_WADDR_BITS-1:0] waddr;
      logic [`TLB_WDATA_BITS-1:0] wdata;
   } cfg_wr_t;

   typedef struct packed {
      logic                                 valid;
      logic                                 rd_en;
      logic                                 wr_en;
      logic [`TLB_VA_BITS-`TLB_PAGE_BITS-1:0] vpn;
   } va_entry_t;

   typedef struct packed {
      logic [`TLB_PA_BITS-`TLB_PAGE_BITS-1:0] ppn;
   } pa_entry_t;

   // Same write word as seen by the VA banks or by the PA table
   typedef union packed {
      struct packed {
         logic [`TLB_WDATA_BITS-$bits(va_entry_t)-1:0] pad;
         va_entry_t                                    entry;
      } va;
      struct packed {
         logic [`TLB_WDATA_BITS-$bits(pa_entry_t)-1:0] pad;
         pa_entry_t                                    entry;
      } pa;
   } tlb_wdata_u;

   typedef struct packed {
      logic hit;
      logic prot;
      logic half;   // 1 when the upper half matched
   } bank_status_t;

   typedef struct packed {
      logic hit;
      logic miss;
      logic prot;
   } l2_result_t;

endpackage

//--- verilog/l2_scan_counter.sv
`include "tlb_consts.svh"

module l2_scan_counter (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      start_i,
   input  logic                      en_i,
   output logic [`TLB_OFF_BITS-1:0]  offset_o,
   output logic                      last_o
);

   logic [`TLB_OFF_BITS-1:0] offset_q;

   // Every search starts from offset 0
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         offset_q <= '0;
      end else if (start_i) begin
         offset_q <= '0;
      end else if (en_i) begin
         offset_q <= offset_q + 1'b1;
      end
   end

   assign offset_o = offset_q;
   assign last_o   = (offset_q == `TLB_OFF_BITS'(`TLB_OFFSETS - 1));

   // The FSM stops stepping once the final offset is out
   a_no_step_past_last: assert property (
      @(posedge clk_i) disable iff (!rst_ni) en_i |-> !last_o);

endmodule

//--- verilog/va_bank.sv
`include "tlb_consts.svh"

module va_bank #(
   parameter int unsigned BANK_ID = 0
) (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  tlb_pkg::cfg_wr_t          cfg_i,
   input  tlb_pkg::lookup_req_t      req_i,
   input  logic [`TLB_SET_BITS-1:0]  set_i,
   input  logic [`TLB_OFF_BITS-1:0]  offset_i,
   output tlb_pkg::bank_status_t     status_o
);
   import tlb_pkg::*;

   localparam int unsigned ROWS     = `TLB_SETS * `TLB_OFFSETS;
   localparam int unsigned ROW_BITS = `TLB_SET_BITS + `TLB_OFF_BITS;

   va_entry_t                               mem_lo [ROWS];  // Half 0 of each set
   va_entry_t                               mem_hi [ROWS];  // Half 1
   logic [ROWS-1:0]                         vld_lo, vld_hi;
   tlb_wdata_u                              wd;
   va_index_t                               wr_idx;
   logic [ROW_BITS-1:0]                     wr_row, rd_row;
   logic                                    bank_we, wr_half;
   va_entry_t                               ent_lo_q, ent_hi_q;
   logic                                    vld_lo_q, vld_hi_q;
   logic                                    match_lo, match_hi, sel_perm;
   logic [`TLB_VA_BITS-`TLB_PAGE_BITS-1:0]  req_vpn;

   //////////////////////////////
   // Write decode
   assign wd      = cfg_i.wdata;
   assign bank_we = cfg_i.we && !cfg_i.waddr[`TLB_WADDR_BITS-1] &&
                    (cfg_i.waddr[`TLB_BANK_BITS-1:0] == `TLB_BANK_BITS'(BANK_ID));
   assign wr_idx  = cfg_i.waddr[`TLB_BANK_BITS +: $bits(va_index_t)];
   assign wr_half = wr_idx[`TLB_OFF_BITS];
   assign wr_row  = {wr_idx[$bits(va_index_t)-1 -: `TLB_SET_BITS],
                     wr_idx[`TLB_OFF_BITS-1:0]};
   assign rd_row  = {set_i, offset_i};

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         vld_lo   <= '0;
         vld_hi   <= '0;
         vld_lo_q <= 1'b0;
         vld_hi_q <= 1'b0;
      end else begin
         if (bank_we && !wr_half) vld_lo[wr_row] <= wd.va.entry.valid;
         if (bank_we && wr_half)  vld_hi[wr_row] <= wd.va.entry.valid;
         vld_lo_q <= vld_lo[rd_row];
         vld_hi_q <= vld_hi[rd_row];
      end
   end

   always_ff @(posedge clk_i) begin
      if (bank_we && !wr_half) mem_lo[wr_row] <= wd.va.entry;
      if (bank_we && wr_half)  mem_hi[wr_row] <= wd.va.entry;
      ent_lo_q <= mem_lo[rd_row];  // Both halves read together
      ent_hi_q <= mem_hi[rd_row];
   end

   //////////////////////////////
   // Compare
   assign req_vpn  = req_i.vaddr[`TLB_VA_BITS-1:`TLB_PAGE_BITS];
   assign match_lo = vld_lo_q && (ent_lo_q.vpn == req_vpn);
   assign match_hi = vld_hi_q && (ent_hi_q.vpn == req_vpn);

   // Lower half wins if both match
   always_comb begin
      sel_perm = req_i.write ? ent_lo_q.wr_en : ent_lo_q.rd_en;
      if (!match_lo) sel_perm = req_i.write ? ent_hi_q.wr_en : ent_hi_q.rd_en;
   end

   assign status_o.hit  = (match_lo || match_hi) && sel_perm;
   assign status_o.prot = (match_lo || match_hi) && !sel_perm;
   assign status_o.half = match_hi && !match_lo;

endmodule

//--- verilog/pa_table.sv
`include "tlb_consts.svh"

module pa_table (
   input  logic                      clk_i,
   input  tlb_pkg::cfg_wr_t          cfg_i,
   input  logic                      rd_en_i,
   input  tlb_pkg::pa_index_t        index_i,
   input  tlb_pkg::lookup_req_t      req_i,
   input  tlb_pkg::l2_result_t       result_i,
   output logic [`TLB_PA_BITS-1:0]   addr_o
);
   import tlb_pkg::*;

   // One entry per VA slot in every bank
   localparam int unsigned DEPTH = `TLB_SETS * `TLB_OFFSETS * 2 * `TLB_BANKS;

   pa_entry_t                mem [DEPTH];
   pa_entry_t                rd_q;
   tlb_wdata_u               wd;
   pa_index_t                wr_idx;
   logic                     pa_we;
   logic [`TLB_PA_BITS-1:0]  addr_new, addr_q;

   //////////////////////////////
   // Storage
   assign wd     = cfg_i.wdata;
   assign pa_we  = cfg_i.we && cfg_i.waddr[`TLB_WADDR_BITS-1];  // PA select bit
   assign wr_idx = cfg_i.waddr[$bits(pa_index_t)-1:0];

   always_ff @(posedge clk_i) begin
      if (pa_we) mem[wr_idx] <= wd.pa.entry;
      if (rd_en_i) rd_q <= mem[index_i];
   end

   //////////////////////////////
   // Output address
   assign addr_new = {rd_q.ppn, req_i.vaddr[`TLB_PAGE_BITS-1:0]};

   always_ff @(posedge clk_i) begin
      if (result_i.hit) addr_q <= addr_new;
   end

   // Live in the hit cycle, held afterwards
   assign addr_o = result_i.hit ? addr_new : addr_q;

endmodule

//--- verilog/l2_ctrl_fsm.sv
`include "tlb_consts.svh"

module l2_ctrl_fsm (
   input  logic                                  clk_i,
   input  logic                                  rst_ni,
   input  logic                                  l1_miss_i,
   input  tlb_pkg::lookup_req_t                  req_i,
   input  logic                                  trans_sent_i,
   input  logic [`TLB_OFF_BITS-1:0]              offset_i,
   input  logic                                  last_i,
   input  tlb_pkg::bank_status_t [`TLB_BANKS-1:0] status_i,
   output logic                                  scan_start_o,
   output logic                                  scan_en_o,
   output tlb_pkg::lookup_req_t                  req_o,
   output logic [`TLB_SET_BITS-1:0]              set_o,
   output logic                                  pa_rd_en_o,
   output tlb_pkg::pa_index_t                    pa_index_o,
   output tlb_pkg::l2_result_t                   result_o,
   output logic                                  busy_o
);
   import tlb_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE, ST_SEARCH, ST_DRAIN, ST_PA_READ, ST_REPORT, ST_WAIT_SENT
   } state_e;

   state_e                      state_q, state_d;
   lookup_req_t                 req_q;
   logic [`TLB_OFF_BITS-1:0]    off_q;      // Offset whose status is on status_i
   logic                        vld_q;      // status_i belongs to this search
   pa_index_t                   pa_idx_q, hit_index;
   l2_result_t                  result_q, result_d;
   logic                        any_hit, any_prot, hit_half, idx_load;
   logic [`TLB_BANK_BITS-1:0]   hit_bank;

   assign set_o = req_q.vaddr[`TLB_PAGE_BITS +: `TLB_SET_BITS];

   //////////////////////////////
   // Hit priority goes to the lowest bank
   always_comb begin
      any_hit  = 1'b0;
      any_prot = 1'b0;
      hit_bank = '0;
      hit_half = 1'b0;
      for (int b = `TLB_BANKS - 1; b >= 0; b--) begin
         any_prot = any_prot | status_i[b].prot;
         if (status_i[b].hit) begin
            any_hit  = 1'b1;
            hit_bank = `TLB_BANK_BITS'(b);
            hit_half = status_i[b].half;
         end
      end
   end

   assign hit_index = {set_o, hit_half, off_q, hit_bank};

   //////////////////////////////
   // Next state
   always_comb begin
      state_d      = state_q;
      scan_start_o = 1'b0;
      scan_en_o    = 1'b0;
      pa_rd_en_o   = 1'b0;
      idx_load     = 1'b0;
      result_d     = '0;
      case (state_q)
         ST_IDLE: begin
            if (l1_miss_i) begin
               scan_start_o = 1'b1;
               state_d      = ST_SEARCH;
            end
         end
         ST_SEARCH: begin
            scan_en_o = !last_i;
            if (vld_q && any_prot) begin
               result_d.prot = 1'b1;
               state_d       = ST_REPORT;
            end else if (vld_q && any_hit) begin
               idx_load = 1'b1;
               state_d  = ST_PA_READ;
            end else if (last_i) begin
               state_d = ST_DRAIN;
            end
         end
         ST_DRAIN: begin   // Status of the last offset
            if (any_prot) begin
               result_d.prot = 1'b1;
               state_d       = ST_REPORT;
            end else if (any_hit) begin
               idx_load = 1'b1;
               state_d  = ST_PA_READ;
            end else begin
               result_d.miss = 1'b1;
               state_d       = ST_REPORT;
            end
         end
         ST_PA_READ: begin
            pa_rd_en_o   = 1'b1;
            result_d.hit = 1'b1;
            state_d      = ST_REPORT;
         end
         ST_REPORT: begin
            if (result_q.hit && !trans_sent_i) state_d = ST_WAIT_SENT;
            else                               state_d = ST_IDLE;
         end
         ST_WAIT_SENT: begin
            if (trans_sent_i) state_d = ST_IDLE;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q  <= ST_IDLE;
         vld_q    <= 1'b0;
         result_q <= '0;
      end else begin
         state_q  <= state_d;
         vld_q    <= (state_q == ST_SEARCH);
         result_q <= result_d;
      end
   end

   always_ff @(posedge clk_i) begin
      off_q <= offset_i;   // Matches the one-cycle bank read
      if (scan_start_o) req_q <= req_i;
      if (idx_load) pa_idx_q <= hit_index;
   end

   assign req_o      = req_q;
   assign pa_index_o = pa_idx_q;
   assign result_o   = result_q;
   assign busy_o     = (state_q != ST_IDLE);

   a_no_lookup_while_busy: assert property (
      @(posedge clk_i) disable iff (!rst_ni) l1_miss_i |-> !busy_o);

   a_result_onehot: assert property (
      @(posedge clk_i) disable iff (!rst_ni) $onehot0(result_o));

endmodule

//--- verilog/tlb_l2_top.sv
`include "tlb_consts.svh"

module tlb_l2_top (
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      l1_miss_i,
   input  tlb_pkg::lookup_req_t      req_i,
   input  tlb_pkg::cfg_wr_t          cfg_i,
   input  logic                      trans_sent_i,
   output tlb_pkg::l2_result_t       result_o,
   output logic                      busy_o,
   output logic [`TLB_PA_BITS-1:0]   out_addr_o
);
   import tlb_pkg::*;

   logic                                scan_start;
   logic                                scan_en;
   logic [`TLB_OFF_BITS-1:0]            offset;
   logic                                last;
   lookup_req_t                         req;
   logic [`TLB_SET_BITS-1:0]            set;
   bank_status_t [`TLB_BANKS-1:0]       bank_status;
   logic                                pa_rd_en;
   pa_index_t                           pa_index;
   l2_result_t                          result;

   //////////////////////////////
   // Control
   l2_ctrl_fsm u_ctrl (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .l1_miss_i    (l1_miss_i),
      .req_i        (req_i),
      .trans_sent_i (trans_sent_i),
      .offset_i     (offset),
      .last_i       (last),
      .status_i     (bank_status),
      .scan_start_o (scan_start),
      .scan_en_o    (scan_en),
      .req_o        (req),
      .set_o        (set),
      .pa_rd_en_o   (pa_rd_en),
      .pa_index_o   (pa_index),
      .result_o     (result),
      .busy_o       (busy_o)
   );

   l2_scan_counter u_scan (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .start_i  (scan_start),
      .en_i     (scan_en),
      .offset_o (offset),
      .last_o   (last)
   );

   //////////////////////////////
   // Tables
   for (genvar b = 0; b < `TLB_BANKS; b++) begin : g_bank
      va_bank #(
         .BANK_ID (b)
      ) u_va_bank (
         .clk_i    (clk_i),
         .rst_ni   (rst_ni),
         .cfg_i    (cfg_i),
         .req_i    (req),
         .set_i    (set),
         .offset_i (offset),
         .status_o (bank_status[b])
      );
   end

   pa_table u_pa_table (
      .clk_i    (clk_i),
      .cfg_i    (cfg_i),
      .rd_en_i  (pa_rd_en),
      .index_i  (pa_index),
      .req_i    (req),
      .result_i (result),
      .addr_o   (out_addr_o)
   );

   assign result_o = result;

endmodule

//--- tests/tb_clock_gen.sv
module tb_clock_gen #(
   parameter int RESET_CYCLES = 10
) (
   output logic clk_o,
   output logic rst_no
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;   // 20 ns period
   end

   initial begin
      rst_no = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2;
      rst_no = 1'b1;
   end

endmodule

//--- tests/tb_tlb_l2.sv
`include "tlb_consts.svh"

module tb_tlb_l2;
   timeunit 1ns;
   timeprecision 1ps;
   import tlb_pkg::*;

   localparam int MAPS      = 32;            // One per bank, half and offset
   localparam int MISSES    = 8;
   localparam int N_LOOKUPS = MAPS + MAPS / 2 + MISSES;
   localparam int VPN_W     = `TLB_VA_BITS - `TLB_PAGE_BITS;
   localparam int PPN_W     = `TLB_PA_BITS - `TLB_PAGE_BITS;

   logic                     clk_i, rst_n;
   logic                     l1_miss_i, trans_sent_i, busy_o;
   lookup_req_t              req_i;
   cfg_wr_t                  cfg_i;
   l2_result_t               result_o, exp_result;
   logic [`TLB_PA_BITS-1:0]  out_addr_o, exp_addr;

   logic [VPN_W-1:0]         m_vpn [MAPS];   // Model of the written tables
   logic [PPN_W-1:0]         m_ppn [MAPS];
   logic                     m_rd [MAPS];
   logic                     m_wr [MAPS];

   integer  seed = 32'h3473_4a8c;
   int      errors = 0;
   int      n_hit = 0;
   int      n_miss = 0;
   int      n_prot = 0;
   logic    rst_seen_q = 1'b0;
   logic    pending, await_sent;
   int      lat_cnt;

   tb_clock_gen #(.RESET_CYCLES(10)) u_clk (.clk_o(clk_i), .rst_no(rst_n));

   tlb_l2_top dut_i (
      .clk_i        (clk_i),
      .rst_ni       (rst_n),
      .l1_miss_i    (l1_miss_i),
      .req_i        (req_i),
      .cfg_i        (cfg_i),
      .trans_sent_i (trans_sent_i),
      .result_o     (result_o),
      .busy_o       (busy_o),
      .out_addr_o   (out_addr_o)
   );

   //////////////////////////////
   // Lookup tracking for the checks
   always @(posedge clk_i) begin
      rst_seen_q <= !rst_n;
      if (!rst_n) begin
         pending    <= 1'b0;
         await_sent <= 1'b0;
         lat_cnt    <= 0;
      end else begin
         if (l1_miss_i) begin
            pending <= 1'b1;
            lat_cnt <= 1;
         end else if (pending && result_o != '0) begin
            pending <= 1'b0;
         end else if (pending) begin
            lat_cnt <= lat_cnt + 1;
         end
         if (trans_sent_i) await_sent <= 1'b0;
         else if (result_o.hit) await_sent <= 1'b1;  // Hit held for the transfer
      end
   end

   //////////////////////////////
   // Checks
   a_reset_busy: assert property (@(posedge clk_i) rst_seen_q |-> !busy_o)
      else begin
         errors++;
         $display("** Error: busy_o expected 0, got %h", $sampled(busy_o));
      end
   a_reset_result: assert property (@(posedge clk_i) rst_seen_q |-> result_o == '0)
      else begin
         errors++;
         $display("** Error: result_o expected 0, got %h", $sampled(result_o));
      end
   a_busy_rise: assert property (@(posedge clk_i) disable iff (!rst_n) l1_miss_i |=> busy_o)
      else begin
         errors++;
         $display("** Error: busy_o expected 1, got %h", $sampled(busy_o));
      end
   a_result_value: assert property (@(posedge clk_i) disable iff (!rst_n)
         result_o != '0 |-> result_o == exp_result)
      else begin
         errors++;
         $display("** Error: result_o expected %h, got %h", exp_result, $sampled(result_o));
      end
   a_pulse_width: assert property (@(posedge clk_i) disable iff (!rst_n)
         result_o != '0 |=> result_o == '0)
      else begin
         errors++;
         $display("** Error: result_o expected 0, got %h", $sampled(result_o));
      end
   a_latency: assert property (@(posedge clk_i) disable iff (!rst_n) pending |-> lat_cnt <= 8)
      else begin
         errors++;
         $display("No result pulse within 8 cycles of the lookup");
      end
   a_hit_addr: assert property (@(posedge clk_i) disable iff (!rst_n)
         (result_o.hit || await_sent) |-> out_addr_o == exp_addr)
      else begin
         errors++;
         $display("** Error: out_addr_o expected %h, got %h", exp_addr, $sampled(out_addr_o));
      end
   a_busy_fall: assert property (@(posedge clk_i) disable iff (!rst_n)
         (result_o.miss || result_o.prot) |=> !busy_o)
      else begin
         errors++;
         $display("** Error: busy_o expected 0, got %h", $sampled(busy_o));
      end
   a_busy_wait: assert property (@(posedge clk_i) disable iff (!rst_n) await_sent |-> busy_o)
      else begin
         errors++;
         $display("** Error: busy_o expected 1, got %h", $sampled(busy_o));
      end
   a_sent_release: assert property (@(posedge clk_i) disable iff (!rst_n)
         trans_sent_i |=> !busy_o)
      else begin
         errors++;
         $display("** Error: busy_o expected 0, got %h", $sampled(busy_o));
      end

   //////////////////////////////
   // Stimulus helpers
   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   function automatic logic vpn_taken(input logic [VPN_W-1:0] vpn, input int upto);
      for (int i = 0; i < upto; i++) begin
         if (m_vpn[i] == vpn) return 1'b1;
      end
      return 1'b0;
   endfunction

   // Expected response from the model tables
   task automatic predict_response(input logic [31:0] vaddr, input logic wr);
      exp_result = '0;
      exp_result.miss = 1'b1;
      for (int i = 0; i < MAPS; i++) begin
         if (m_vpn[i] == vaddr[31:`TLB_PAGE_BITS]) begin
            exp_result.miss = 1'b0;
            if (wr ? m_wr[i] : m_rd[i]) begin
               exp_result.hit = 1'b1;
               exp_addr = {m_ppn[i], vaddr[`TLB_PAGE_BITS-1:0]};
            end else begin
               exp_result.prot = 1'b1;
            end
         end
      end
   endtask

   task automatic cfg_write(input logic [31:0] addr, input logic [63:0] data);
      cfg_i.we    = 1'b1;
      cfg_i.waddr = addr;
      cfg_i.wdata = data;
      @(posedge clk_i);
      #2;
      cfg_i.we = 1'b0;
   endtask

   task automatic load_mappings();
      logic [31:0]  r;
      logic [4:0]   set;
      logic [9:0]   idx;
      va_entry_t    ve;
      pa_entry_t    pe;
      int           p;
      for (int i = 0; i < MAPS; i++) begin
         r = rand_word();
         set = r[4:0];
         m_vpn[i] = {r[19:5], set};   // Low vpn bits pick the set
         while (vpn_taken(m_vpn[i], i)) begin
            r = rand_word();
            m_vpn[i] = {r[19:5], set};
         end
         p = (i + i / 4) % 4;
         m_rd[i] = (p != 2);
         m_wr[i] = (p != 1);
         r = rand_word();
         m_ppn[i] = r[PPN_W-1:0];
         idx = {set, i[4], i[3:2], i[1:0]};   // {set, half, offset, bank}
         ve = '0;
         ve.valid = 1'b1;
         ve.rd_en = m_rd[i];
         ve.wr_en = m_wr[i];
         ve.vpn   = m_vpn[i];
         cfg_write({22'h0, idx}, {41'h0, ve});
         pe.ppn = m_ppn[i];
         cfg_write({1'b1, 21'h0, idx}, {36'h0, pe});
      end
   endtask

   task automatic wait_result(output l2_result_t res);
      int n;
      res = '0;
      n = 0;
      while (res == '0 && n < 16) begin
         @(posedge clk_i);
         #2;
         res = result_o;
         n++;
      end
      if (res == '0) begin
         errors++;
         $display("No result pulse seen within 16 cycles of the lookup");
      end
   endtask

   task automatic lookup(input logic [31:0] vaddr, input logic wr);
      l2_result_t res;
      int         n;
      predict_response(vaddr, wr);
      req_i.vaddr = vaddr;
      req_i.write = wr;
      l1_miss_i = 1'b1;
      @(posedge clk_i);
      #2;
      l1_miss_i = 1'b0;
      wait_result(res);
      if (res.hit) begin
         n_hit++;
         n = 1 + int'(rand_word() % 6);   // Transfer takes a while
         repeat (n) @(posedge clk_i);
         #2;
         trans_sent_i = 1'b1;
         @(posedge clk_i);
         #2;
         trans_sent_i = 1'b0;
      end
      if (res.miss) n_miss++;
      if (res.prot) n_prot++;
      n = 0;
      while (busy_o && n < 4) begin
         @(posedge clk_i);
         #2;
         n++;
      end
      if (busy_o) begin
         errors++;
         $display("busy_o still high four cycles after the lookup ended");
      end
   endtask

   //////////////////////////////
   // Main sequence
   initial begin
      logic [31:0] r;
      l1_miss_i    = 1'b0;
      trans_sent_i = 1'b0;
      req_i        = '0;
      cfg_i        = '0;
      exp_result   = '0;
      exp_addr     = '0;
      @(posedge rst_n);
      @(posedge clk_i);
      #2;
      load_mappings();
      for (int i = 0; i < MAPS; i++) begin
         r = rand_word();
         lookup({m_vpn[i], r[11:0]}, !m_rd[i]);   // Permitted access
      end
      for (int i = 0; i < MAPS; i++) begin
         if (!(m_rd[i] && m_wr[i])) begin
            r = rand_word();
            lookup({m_vpn[i], r[11:0]}, m_rd[i]);   // Missing permission
         end
      end
      for (int k = 0; k < MISSES; k++) begin
         r = rand_word();
         while (vpn_taken(r[31:`TLB_PAGE_BITS], MAPS)) r = rand_word();
         lookup(r, r[0]);
      end
      repeat (3) @(posedge clk_i);
      $display("Lookups %0d: hits %0d, misses %0d, prot %0d, errors %0d",
               n_hit + n_miss + n_prot, n_hit, n_miss, n_prot, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (N_LOOKUPS * 20 + 200) @(posedge clk_i);
      $display("Watchdog expired before the tests finished, errors %0d", errors);
      $display("Something failed");
      $finish;
   end

endmodule

//--- files.f
+incdir+verilog
verilog/tlb_pkg.sv
verilog/l2_scan_counter.sv
verilog/va_bank.sv
verilog/pa_table.sv
verilog/l2_ctrl_fsm.sv
verilog/tlb_l2_top.sv
tests/tb_clock_gen.sv
tests/tb_tlb_l2.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the L2 TLB testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f files.f \
      --top-module tb_tlb_l2 -Mdir obj_dir -o tb_sim; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
